// File: me_config.svh
`ifndef ME_CONFIG_SVH
`define ME_CONFIG_SVH

// Block geometry. Blocks are square, so a row also holds ME_ROWS pixels.
`define ME_ROWS      8
`define ME_PIX_W     8

// Pixel memory depth in 64-bit words.
`define ME_MEM_WORDS 256

// APB address width and register offsets.
`define ME_APB_AW     8
`define ME_REG_CTRL   8'h00
`define ME_REG_STATUS 8'h04
`define ME_REG_SAD    8'h08
`define ME_REG_THRESH 8'h0C
`define ME_REG_COUNT  8'h10
`define ME_REG_ADDR   8'h14

`endif

// File: me_pkg.sv
`include "me_config.svh"

package me_pkg;

    // One memory word. Pixel k sits at bits 8k+7 down to 8k.
    typedef logic [`ME_ROWS*`ME_PIX_W-1:0] pixel_row_t;

    // Full block. Row r sits at bits 64r+63 down to 64r.
    typedef logic [`ME_ROWS*`ME_ROWS*`ME_PIX_W-1:0] block_t;

    // Byte address into pixel memory.
    typedef logic [31:0] mem_addr_t;

    // 64 * 255 fits in 16 bits.
    typedef logic [15:0] sad_t;

    typedef logic [31:0] apb_data_t;

    typedef enum logic [0:0] {
        FETCH_IDLE,
        FETCH_ROWS
    } fetch_state_t;

endpackage

// File: pixel_mem.sv
`timescale 1ns/1ps
`include "me_config.svh"

module pixel_mem (
    input  logic               clk,
    input  logic               rst,
    input  logic               mem_we,
    input  logic [7:0]         mem_waddr,
    input  me_pkg::pixel_row_t mem_wdata,
    input  me_pkg::mem_addr_t  cur_mem_addr,
    output me_pkg::pixel_row_t cur_in
);
    import me_pkg::*;

    localparam int IDX_W = $clog2(`ME_MEM_WORDS);

    pixel_row_t mem [`ME_MEM_WORDS];
    logic [IDX_W-1:0] rd_idx;

    // Byte address to word index, wrapping at the memory depth.
    assign rd_idx = cur_mem_addr[IDX_W+2:3];
    assign cur_in = mem[rd_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ME_MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (mem_we) begin
            mem[mem_waddr] <= mem_wdata;
        end
    end

endmodule

// File: cur_buffer.sv
`timescale 1ns/1ps
`include "me_config.svh"

module cur_buffer (
    input  logic               clk,
    input  logic               rst,
    input  logic               en,
    input  logic               next_block,  // Start of a block fetch.
    input  me_pkg::pixel_row_t cur_in,
    output me_pkg::block_t     cur_out,
    output me_pkg::mem_addr_t  cur_mem_addr,
    output logic               block_valid,
    output logic               busy
);
    import me_pkg::*;

    localparam int ROW_W = `ME_ROWS * `ME_PIX_W;

    fetch_state_t state;
    logic [2:0]   row_cnt;
    pixel_row_t   rows [`ME_ROWS];

    assign busy = (state == FETCH_ROWS);

    always_comb begin
        for (int r = 0; r < `ME_ROWS; r++) begin
            cur_out[r*ROW_W +: ROW_W] = rows[r];
        end
    end

    // Fetch control. The address steps one word per latched row.
    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= FETCH_IDLE;
            row_cnt      <= '0;
            cur_mem_addr <= '0;
            block_valid  <= 1'b0;
        end else begin
            block_valid <= 1'b0;
            if (en) begin
                case (state)
                    FETCH_IDLE: begin
                        if (next_block) begin
                            state   <= FETCH_ROWS;
                            row_cnt <= '0;
                        end
                    end
                    FETCH_ROWS: begin
                        cur_mem_addr <= cur_mem_addr + 32'd8;
                        row_cnt      <= row_cnt + 3'd1;
                        if (row_cnt == 3'(`ME_ROWS - 1)) begin
                            state       <= FETCH_IDLE;
                            block_valid <= 1'b1;  // Whole block is in place next cycle.
                        end
                    end
                    default: state <= FETCH_IDLE;
                endcase
            end
        end
    end

    // Row storage.
    always_ff @(posedge clk) begin
        if (en && state == FETCH_ROWS) begin
            rows[row_cnt] <= cur_in;
        end
    end

endmodule

// File: sad_engine.sv
`timescale 1ns/1ps
`include "me_config.svh"

module sad_engine (
    input  logic           clk,
    input  logic           rst,
    input  logic           block_valid,
    input  me_pkg::block_t cur_block,
    output me_pkg::sad_t   sad,
    output logic           sad_valid
);
    import me_pkg::*;

    localparam int COLS   = `ME_ROWS;
    localparam int PIX    = `ME_PIX_W;
    localparam int RSUM_W = $clog2(COLS * 255 + 1);

    typedef logic [RSUM_W-1:0] row_sum_t;

    block_t   prev_block;  // Block from the previous fetch.
    row_sum_t row_sum_d [`ME_ROWS];
    row_sum_t row_sum_q [`ME_ROWS];
    logic     s1_valid;
    sad_t     total;

    function automatic logic [PIX-1:0] abs_diff(input logic [PIX-1:0] a,
                                                input logic [PIX-1:0] b);
        return (a > b) ? a - b : b - a;
    endfunction

    // Stage one, per-row sums.
    always_comb begin
        for (int r = 0; r < `ME_ROWS; r++) begin
            row_sum_d[r] = '0;
            for (int c = 0; c < COLS; c++) begin
                row_sum_d[r] = row_sum_d[r]
                    + row_sum_t'(abs_diff(cur_block[(r*COLS+c)*PIX +: PIX],
                                          prev_block[(r*COLS+c)*PIX +: PIX]));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_block <= '0;  // First block is compared against zero.
            s1_valid   <= 1'b0;
        end else begin
            s1_valid <= block_valid;
            if (block_valid) begin
                prev_block <= cur_block;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (block_valid) begin
            row_sum_q <= row_sum_d;
        end
    end

    // Stage two, adder across rows.
    always_comb begin
        total = '0;
        for (int r = 0; r < `ME_ROWS; r++) begin
            total = total + sad_t'(row_sum_q[r]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sad_valid <= 1'b0;
        end else begin
            sad_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            sad <= total;
        end
    end

endmodule

// File: me_regs.sv
`timescale 1ns/1ps
`include "me_config.svh"

module me_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`ME_APB_AW-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  me_pkg::apb_data_t     pwdata,
    input  logic                  busy,
    input  me_pkg::mem_addr_t     cur_mem_addr,
    input  me_pkg::sad_t          sad,
    input  logic                  sad_valid,
    output me_pkg::apb_data_t     prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  en,
    output logic                  next_block
);
    import me_pkg::*;

    logic      ctrl_en;
    logic      done;
    logic      over_thresh;
    sad_t      sad_q;
    sad_t      thresh_q;
    apb_data_t count_q;
    logic      start_q;
    logic      wr_en;
    logic      reg_hit;
    logic      start_ok;

    assign wr_en = psel & penable & pwrite;

    // Start needs enable kept set and an idle buffer.
    assign start_ok = wr_en && (paddr == `ME_REG_CTRL) && pwdata[1] && pwdata[0]
                      && ctrl_en && !busy && !start_q;

    assign pready     = 1'b1;  // No wait states.
    assign pslverr    = psel & penable & ~reg_hit;
    assign en         = ctrl_en;
    assign next_block = start_q;

    // Read mux and address decode.
    always_comb begin
        reg_hit = 1'b1;
        case (paddr)
            `ME_REG_CTRL:   prdata = apb_data_t'(ctrl_en);
            `ME_REG_STATUS: prdata = apb_data_t'({over_thresh, done, busy});
            `ME_REG_SAD:    prdata = apb_data_t'(sad_q);
            `ME_REG_THRESH: prdata = apb_data_t'(thresh_q);
            `ME_REG_COUNT:  prdata = count_q;
            `ME_REG_ADDR:   prdata = cur_mem_addr;
            default: begin
                prdata  = '0;
                reg_hit = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_en     <= 1'b0;
            done        <= 1'b0;
            over_thresh <= 1'b0;
            sad_q       <= '0;
            thresh_q    <= '0;
            count_q     <= '0;
            start_q     <= 1'b0;
        end else begin
            start_q <= start_ok;
            if (wr_en) begin
                case (paddr)
                    `ME_REG_CTRL:   ctrl_en <= pwdata[0];
                    `ME_REG_THRESH: thresh_q <= pwdata[$bits(sad_t)-1:0];
                    default: ;
                endcase
            end
            if (start_ok) begin
                done <= 1'b0;
            end
            if (sad_valid) begin
                sad_q       <= sad;
                count_q     <= count_q + 32'd1;
                done        <= 1'b1;
                over_thresh <= (sad > thresh_q);
            end
        end
    end

endmodule

// File: me_top.sv
`timescale 1ns/1ps
`include "me_config.svh"

module me_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`ME_APB_AW-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  me_pkg::apb_data_t     pwdata,
    output me_pkg::apb_data_t     prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  mem_we,
    input  logic [7:0]            mem_waddr,
    input  me_pkg::pixel_row_t    mem_wdata
);
    import me_pkg::*;

    logic       en;
    logic       next_block;
    logic       block_valid;
    logic       busy;
    logic       sad_valid;
    mem_addr_t  cur_mem_addr;
    pixel_row_t cur_in;
    block_t     cur_out;
    sad_t       sad;

    pixel_mem u_pixel_mem (
        .clk          (clk),
        .rst          (rst),
        .mem_we       (mem_we),
        .mem_waddr    (mem_waddr),
        .mem_wdata    (mem_wdata),
        .cur_mem_addr (cur_mem_addr),
        .cur_in       (cur_in)
    );

    cur_buffer u_cur_buffer (
        .clk          (clk),
        .rst          (rst),
        .en           (en),
        .next_block   (next_block),
        .cur_in       (cur_in),
        .cur_out      (cur_out),
        .cur_mem_addr (cur_mem_addr),
        .block_valid  (block_valid),
        .busy         (busy)
    );

    sad_engine u_sad_engine (
        .clk         (clk),
        .rst         (rst),
        .block_valid (block_valid),
        .cur_block   (cur_out),
        .sad         (sad),
        .sad_valid   (sad_valid)
    );

    me_regs u_me_regs (
        .clk          (clk),
        .rst          (rst),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .busy         (busy),
        .cur_mem_addr (cur_mem_addr),
        .sad          (sad),
        .sad_valid    (sad_valid),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .en           (en),
        .next_block   (next_block)
    );

endmodule

// File: tb_me_top.sv
`timescale 1ns/1ps
`include "me_config.svh"

module tb_me_top;
    import me_pkg::*;

    localparam int MAX_CYCLES = 3000;  // 256-word load plus six fetches with polling.

    logic                  clk;
    logic                  rst;
    logic [`ME_APB_AW-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    apb_data_t             pwdata;
    apb_data_t             prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  mem_we;
    logic [7:0]            mem_waddr;
    pixel_row_t            mem_wdata;

    pixel_row_t shadow [`ME_MEM_WORDS];  // Copy of what was loaded into the DUT.
    integer     seed = 32'h6f25b435;
    int         error_count = 0;
    int         check_count = 0;
    int         cycle_count = 0;
    int         blocks_done = 0;
    logic       last_err;
    apb_data_t  rd_data;
    sad_t       exp_sad;

    me_top dut (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout, run did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    pready_high: assert property (@(posedge clk) disable iff (rst) pready)
        else begin
            error_count++;
            $display("** Error at %0t ns: pready is low", $time);
        end

    // All tasks start and end 2 ns after a rising edge.
    task automatic apb_write(input logic [7:0] addr, input apb_data_t data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #2 penable = 1'b1;
        @(negedge clk);
        last_err = pslverr;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output apb_data_t data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #2 penable = 1'b1;
        @(negedge clk);  // Mid access cycle, prdata is settled.
        data     = prdata;
        last_err = pslverr;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_value(input string what, input apb_data_t got, input apb_data_t exp);
        check_count++;
        assert (got == exp) else begin
            error_count++;
            $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic read_check(input string what, input logic [7:0] addr, input apb_data_t exp);
        apb_data_t got;
        apb_read(addr, got);
        check_value(what, got, exp);
    endtask

    // Block n covers words 8n..8n+7 and is compared with block n-1, or zero for n = 0.
    function automatic sad_t expected_sad(input int n);
        int total;
        int a;
        int b;
        total = 0;
        for (int r = 0; r < 8; r++) begin
            for (int c = 0; c < 8; c++) begin
                a = shadow[(8*n+r) % `ME_MEM_WORDS][8*c +: 8];
                b = (n == 0) ? 0 : shadow[(8*(n-1)+r) % `ME_MEM_WORDS][8*c +: 8];
                total += (a > b) ? a - b : b - a;
            end
        end
        return sad_t'(total);
    endfunction

    task automatic wait_done;
        apb_data_t st;
        int        polls;
        polls = 0;
        do begin
            apb_read(`ME_REG_STATUS, st);
            polls++;
        end while (!st[1] && polls < 100);
        if (!st[1]) begin
            error_count++;
            $display("Done bit still clear after %0d STATUS polls", polls);
        end
    endtask

    task automatic check_result(input sad_t exp, input sad_t thresh);
        wait_done();
        blocks_done++;
        read_check("SAD", `ME_REG_SAD, apb_data_t'(exp));
        read_check("COUNT", `ME_REG_COUNT, blocks_done);
        read_check("ADDR", `ME_REG_ADDR, 64 * blocks_done);
        read_check("STATUS", `ME_REG_STATUS, apb_data_t'({exp > thresh, 2'b10}));
    endtask

    task automatic run_block(input sad_t thresh);
        sad_t exp;
        exp = expected_sad(blocks_done);
        apb_write(`ME_REG_THRESH, apb_data_t'(thresh));
        apb_write(`ME_REG_CTRL, 32'h3);
        check_result(exp, thresh);
    endtask

    initial begin
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        mem_we    = 1'b0;
        mem_waddr = '0;
        mem_wdata = '0;
        repeat (5) @(posedge clk);
        #2 rst = 1'b0;

        read_check("STATUS", `ME_REG_STATUS, 0);
        read_check("SAD", `ME_REG_SAD, 0);
        read_check("COUNT", `ME_REG_COUNT, 0);
        read_check("ADDR", `ME_REG_ADDR, 0);
        apb_write(`ME_REG_THRESH, 32'h1234);
        read_check("THRESH", `ME_REG_THRESH, 32'h1234);
        check_value("pslverr", apb_data_t'(last_err), 0);

        for (int i = 0; i < `ME_MEM_WORDS; i++) begin
            shadow[i] = {$random(seed), $random(seed)};
            mem_we    = 1'b1;
            mem_waddr = 8'(i);
            mem_wdata = shadow[i];
            @(posedge clk);
            #2;
        end
        mem_we = 1'b0;

        apb_write(`ME_REG_CTRL, 32'h1);
        run_block(16'hffff);  // Block 0 against zero.
        exp_sad = expected_sad(blocks_done);
        run_block(exp_sad + 16'd1);
        exp_sad = expected_sad(blocks_done);
        run_block(exp_sad - 16'd1);
        exp_sad = expected_sad(blocks_done);
        run_block(exp_sad);  // Equal is not over.

        // Start with enable clear must not fetch, even when the same write sets enable.
        apb_write(`ME_REG_CTRL, 32'h0);
        apb_write(`ME_REG_CTRL, 32'h3);
        repeat (20) @(posedge clk);
        #2;
        read_check("COUNT", `ME_REG_COUNT, blocks_done);
        read_check("ADDR", `ME_REG_ADDR, 64 * blocks_done);
        apb_write(`ME_REG_CTRL, 32'h1);

        // Second start lands while the first fetch is busy.
        exp_sad = expected_sad(blocks_done);
        apb_write(`ME_REG_CTRL, 32'h3);
        apb_write(`ME_REG_CTRL, 32'h3);
        check_result(exp_sad, exp_sad);
        run_block(16'h0);

        apb_read(8'h18, rd_data);
        check_value("unmapped read data", rd_data, 0);
        check_value("pslverr on unmapped read", apb_data_t'(last_err), 1);
        apb_write(8'h20, 32'hdeadbeef);
        check_value("pslverr on unmapped write", apb_data_t'(last_err), 1);
        read_check("COUNT", `ME_REG_COUNT, blocks_done);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+.
me_pkg.sv
pixel_mem.sv
cur_buffer.sv
sad_engine.sv
me_regs.sv
me_top.sv
tb_me_top.sv
